//--- source/msp16Pkg.sv
package msp16Pkg;

   localparam int dataW    = 16;                    // Register and data width
   localparam int regIdxW  = 4;                     // Register index width
   localparam int numRegs  = 16;                    // R0 to R15
   localparam int axiAddrW = 8;                     // Debug bus byte address
   localparam int axiDataW = 32;                    // Debug bus data width

   localparam logic [regIdxW-1:0] regPc = 4'd0;     // Program counter
   localparam logic [regIdxW-1:0] regSp = 4'd1;     // Stack pointer
   localparam logic [regIdxW-1:0] regSr = 4'd2;     // Status register, also CG1
   localparam logic [regIdxW-1:0] regCg = 4'd3;     // Constant generator CG2

   localparam logic [3:0] fmt1MinOp = 4'h4;         // Lowest double-operand nibble

   // Constants produced by R2 and R3
   localparam logic [dataW-1:0] cgZero     = 16'h0000;
   localparam logic [dataW-1:0] cgOne      = 16'h0001;
   localparam logic [dataW-1:0] cgTwo      = 16'h0002;
   localparam logic [dataW-1:0] cgFour     = 16'h0004;
   localparam logic [dataW-1:0] cgEight    = 16'h0008;
   localparam logic [dataW-1:0] cgMinusOne = 16'hFFFF;

   typedef struct packed {
      logic [3:0]         opcode;                   // 4 and up
      logic [regIdxW-1:0] srcReg;
      logic               dstMode;                  // Ad
      logic               byteOp;                   // B/W
      logic [1:0]         srcMode;                  // As
      logic [regIdxW-1:0] dstReg;
   } opFmt1;

   typedef struct packed {
      logic [8:0]         opcode;
      logic               byteOp;
      logic [1:0]         mode;
      logic [regIdxW-1:0] regIdx;                   // Single operand register
   } opFmt2;

   typedef union packed {
      opFmt1            f1;                         // Double operand view
      opFmt2            f2;                         // Single operand view
      logic [dataW-1:0] raw;
   } instrWord;

   typedef struct packed {
      logic [regIdxW-1:0] srcReg;
      logic [regIdxW-1:0] dstReg;
      logic [1:0]         srcMode;
      logic               dstMode;
      logic               byteOp;
   } opFields;

   typedef struct packed {
      logic [axiAddrW-1:0] awaddr;
      logic                awvalid;
      logic [axiDataW-1:0] wdata;
      logic                wvalid;
      logic                bready;
      logic [axiAddrW-1:0] araddr;
      logic                arvalid;
      logic                rready;
   } axiReq;

   typedef struct packed {
      logic                awready;
      logic                wready;
      logic                bvalid;
      logic                arready;
      logic                rvalid;
      logic [axiDataW-1:0] rdata;
   } axiRsp;

   typedef struct packed {
      logic               valid;                    // Pending debug write
      logic [regIdxW-1:0] index;
      logic [dataW-1:0]   data;
   } dbgWr;

endpackage

//--- source/instrDecode.sv
`timescale 1ns/1ns

module instrDecode
   import msp16Pkg::*;
(
   input  instrWord instr,                          // Raw instruction word
   output opFields  fields                          // Decoded operand fields
);

   logic isFmt1;                                    // Double operand word

   // Top nibble 4..F is double operand, the rest single operand or jump
   assign isFmt1 = (instr.f1.opcode >= fmt1MinOp);

   always_comb
   begin
      if (isFmt1)
      begin
         fields.srcReg  = instr.f1.srcReg;
         fields.dstReg  = instr.f1.dstReg;
         fields.srcMode = instr.f1.srcMode;
         fields.dstMode = instr.f1.dstMode;
         fields.byteOp  = instr.f1.byteOp;
      end
      else
      begin
         // One register serves as both source and destination
         fields.srcReg  = instr.f2.regIdx;
         fields.dstReg  = instr.f2.regIdx;
         fields.srcMode = instr.f2.mode;
         fields.dstMode = instr.f2.mode[0];         // Low mode bit only
         fields.byteOp  = instr.f2.byteOp;          // Jumps land here too
      end
   end

endmodule

//--- source/constGen.sv
`timescale 1ns/1ns

module constGen
   import msp16Pkg::*;
(
   input  opFields          fields,                 // Decoded operand fields
   output logic             constValid,             // Source is a constant
   output logic [dataW-1:0] constVal                // Generated constant
);

   always_comb
   begin
      constValid = 1'b0;                            // Default is a real read
      constVal   = cgZero;
      if (fields.srcReg == regSr)
      begin
         // R2 mode 0 is the status register itself
         case (fields.srcMode)
            2'd1:    constVal = cgZero;             // Absolute addressing base
            2'd2:    constVal = cgFour;
            2'd3:    constVal = cgEight;
            default: constVal = cgZero;
         endcase
         constValid = (fields.srcMode != 2'd0);
      end
      else if (fields.srcReg == regCg)
      begin
         constValid = 1'b1;                         // R3 is always a constant
         case (fields.srcMode)
            2'd0:    constVal = cgZero;
            2'd1:    constVal = cgOne;
            2'd2:    constVal = cgTwo;
            default: constVal = cgMinusOne;
         endcase
      end
   end

endmodule

//--- source/regFile.sv
`timescale 1ns/1ns

module regFile
   import msp16Pkg::*;
(
   input  logic               clk,
   input  logic               rstN,
   input  opFields            fields,               // Read and write addresses
   input  logic               rw,                   // Core write-back enable
   input  logic [dataW-1:0]   din,                  // Core write-back data
   input  logic [dataW-1:0]   pcIn,                 // Next PC
   input  logic [dataW-1:0]   srIn,                 // Flag update value
   input  logic               srWe,                 // Flag update enable
   input  dbgWr               dbgW,                 // Debug write request
   output logic               dbgGrant,             // Debug write may proceed
   input  logic [regIdxW-1:0] dbgRdIdx,             // Debug read address
   output logic [dataW-1:0]   dbgRdData,
   output logic [dataW-1:0]   srcRaw,               // Source before constant mux
   output logic [dataW-1:0]   dstRaw,
   output logic [dataW-1:0]   pcOut,
   output logic [dataW-1:0]   spOut,
   output logic [dataW-1:0]   srOut
);

   logic [dataW-1:0]   regs [numRegs];              // R0 to R15
   logic               wrEn;                        // Shared write port active
   logic [regIdxW-1:0] wrIdx;
   logic [dataW-1:0]   wrData;
   logic               wrPc;                        // Explicit write to R0
   logic               wrSr;                        // Explicit write to R2
   logic               wrGen;                       // Write to R1 or R4..R15

   // Core owns the port whenever it writes
   assign dbgGrant = ~rw;
   assign wrEn     = rw | dbgW.valid;
   assign wrIdx    = rw ? fields.dstReg : dbgW.index;
   assign wrData   = rw ? din : dbgW.data;

   assign wrPc  = wrEn && (wrIdx == regPc);
   assign wrSr  = wrEn && (wrIdx == regSr);
   assign wrGen = wrEn && (wrIdx != regPc) && (wrIdx != regSr) && (wrIdx != regCg);

   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
      begin
         for (int i = 0; i < numRegs; i++)
         begin
            regs[i] <= '0;
         end
      end
      else
      begin
         // PC loads every edge
         if (wrPc)
         begin
            regs[regPc] <= wrData;
         end
         else
         begin
            regs[regPc] <= pcIn;
         end

         // Explicit write beats the flag update
         if (wrSr)
         begin
            regs[regSr] <= wrData;
         end
         else if (srWe)
         begin
            regs[regSr] <= srIn;
         end

         if (wrGen)
         begin
            regs[wrIdx] <= wrData;                  // R3 never lands here
         end
      end
   end

   // Combinational reads of last edge state
   assign srcRaw    = regs[fields.srcReg];
   assign dstRaw    = regs[fields.dstReg];
   assign dbgRdData = regs[dbgRdIdx];
   assign pcOut     = regs[regPc];
   assign spOut     = regs[regSp];
   assign srOut     = regs[regSr];

endmodule

//--- source/debugAxiLite.sv
`timescale 1ns/1ns

module debugAxiLite
   import msp16Pkg::*;
(
   input  logic               clk,
   input  logic               rstN,
   input  axiReq              req,                  // Host to slave
   output axiRsp              rsp,                  // Slave to host
   output dbgWr               dbgW,                 // Write request to regFile
   input  logic               dbgGrant,             // Low while core writes
   output logic [regIdxW-1:0] dbgRdIdx,
   input  logic [dataW-1:0]   dbgRdData
);

   logic               wrPend;                      // Holding a write for the port
   logic               bvalidQ;
   logic [regIdxW-1:0] wrIdxQ;
   logic [dataW-1:0]   wrDataQ;
   logic               wrIdle;                      // Ready for AW and W
   logic               wrAccept;
   logic               rdPend;                      // Index captured, data next
   logic               rvalidQ;
   logic [regIdxW-1:0] rdIdxQ;
   logic [dataW-1:0]   rdataQ;
   logic               rdIdle;
   logic               rdAccept;

   assign wrIdle   = ~wrPend & ~bvalidQ;
   assign wrAccept = wrIdle & req.awvalid & req.wvalid;   // Address and data together
   assign rdIdle   = ~rdPend & ~rvalidQ;
   assign rdAccept = rdIdle & req.arvalid;

   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
      begin
         wrPend  <= 1'b0;
         bvalidQ <= 1'b0;
         rdPend  <= 1'b0;
         rvalidQ <= 1'b0;
      end
      else
      begin
         if (wrAccept)
            wrPend <= 1'b1;
         else if (wrPend && dbgGrant)
            wrPend <= 1'b0;                         // Written this edge
         if (wrPend && dbgGrant)
            bvalidQ <= 1'b1;
         else if (bvalidQ && req.bready)
            bvalidQ <= 1'b0;
         rdPend <= rdAccept;                        // One cycle to fetch data
         if (rdPend)
            rvalidQ <= 1'b1;
         else if (rvalidQ && req.rready)
            rvalidQ <= 1'b0;
      end
   end

   // Payload capture
   always_ff @(posedge clk)
   begin
      if (wrAccept)
      begin
         wrIdxQ  <= req.awaddr[5:2];                // Word address
         wrDataQ <= req.wdata[dataW-1:0];           // Low half only
      end
      if (rdAccept)
         rdIdxQ <= req.araddr[5:2];
      if (rdPend)
         rdataQ <= dbgRdData;
   end

   assign dbgW.valid = wrPend;
   assign dbgW.index = wrIdxQ;
   assign dbgW.data  = wrDataQ;
   assign dbgRdIdx   = rdIdxQ;

   assign rsp.awready = wrIdle;
   assign rsp.wready  = wrIdle;
   assign rsp.bvalid  = bvalidQ;
   assign rsp.arready = rdIdle;                     // Low while a read is in flight
   assign rsp.rvalid  = rvalidQ;
   assign rsp.rdata   = {{(axiDataW-dataW){1'b0}}, rdataQ};   // Zero-extended

endmodule

//--- source/msp16RegCore.sv
`timescale 1ns/1ns

module msp16RegCore
   import msp16Pkg::*;
(
   input  logic             clk,
   input  logic             rstN,
   input  instrWord         instr,                  // Current instruction
   input  logic             rw,                     // Write-back enable
   input  logic [dataW-1:0] din,                    // Write-back data
   input  logic [dataW-1:0] pcIn,
   input  logic [dataW-1:0] srIn,
   input  logic             srWe,
   input  axiReq            dbgReq,                 // Debug host request
   output logic [dataW-1:0] srcOperand,
   output logic [dataW-1:0] dstOperand,
   output logic             isConst,                // Source from constant generator
   output logic [dataW-1:0] pcOut,
   output logic [dataW-1:0] spOut,
   output logic [dataW-1:0] srOut,
   output logic             byteOp,
   output axiRsp            dbgRsp                  // Debug host response
);

   opFields            fields;
   logic               constValid;
   logic [dataW-1:0]   constVal;
   logic [dataW-1:0]   srcRaw;                      // Register value before mux
   dbgWr               dbgW;
   logic               dbgGrant;
   logic [regIdxW-1:0] dbgRdIdx;
   logic [dataW-1:0]   dbgRdData;

   instrDecode uDecode (
      .instr  (instr),
      .fields (fields)
   );

   constGen uConstGen (
      .fields     (fields),
      .constValid (constValid),
      .constVal   (constVal)
   );

   regFile uRegFile (
      .clk       (clk),
      .rstN      (rstN),
      .fields    (fields),
      .rw        (rw),
      .din       (din),
      .pcIn      (pcIn),
      .srIn      (srIn),
      .srWe      (srWe),
      .dbgW      (dbgW),
      .dbgGrant  (dbgGrant),
      .dbgRdIdx  (dbgRdIdx),
      .dbgRdData (dbgRdData),
      .srcRaw    (srcRaw),
      .dstRaw    (dstOperand),
      .pcOut     (pcOut),
      .spOut     (spOut),
      .srOut     (srOut)
   );

   debugAxiLite uDebug (
      .clk       (clk),
      .rstN      (rstN),
      .req       (dbgReq),
      .rsp       (dbgRsp),
      .dbgW      (dbgW),
      .dbgGrant  (dbgGrant),
      .dbgRdIdx  (dbgRdIdx),
      .dbgRdData (dbgRdData)
   );

   // Constant replaces the register value
   assign srcOperand = constValid ? constVal : srcRaw;
   assign isConst    = constValid;
   assign byteOp     = fields.byteOp;

endmodule

//--- sim/clockGen.sv
`timescale 1ns/1ns

module clockGen
(
   output logic clk
);

   localparam int halfPeriod = 4;                   // 8 ns period

   initial
   begin
      clk = 1'b0;
   end

   always #halfPeriod clk = ~clk;

endmodule

//--- sim/msp16RegCoreTb.sv
`timescale 1ns/1ns

module msp16RegCoreTb
   import msp16Pkg::*;
();

   localparam int maxCycles = 2000;                 // Tests need about 300 cycles
   localparam logic [31:0] lfsrPoly = 32'h80200003;

   logic        clk;
   logic        rstN;
   logic [15:0] instr;                              // Raw word into the union port
   logic        rw;
   logic [15:0] din, pcIn, srIn;
   logic        srWe;
   axiReq       dbgReq;
   axiRsp       dbgRsp;
   logic [15:0] srcOperand, dstOperand;
   logic [15:0] pcOut, spOut, srOut;
   logic        isConst, byteOp;
   logic [15:0] model [numRegs];                    // Shadow registers
   logic [31:0] lfsrState;
   int          errors = 0;
   int          checks = 0;
   int          cycles = 0;

   clockGen uClock (.clk(clk));

   msp16RegCore DUT (.*);

   function automatic logic [15:0] randBits(input int n);
      logic [15:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ lfsrPoly) : (lfsrState >> 1);
         v = {v[14:0], lfsrState[0]};               // One step per bit
      end
      return v;
   endfunction

   // Double-operand word, opcode 4, Ad 0
   function automatic logic [15:0] fmt1Word(input logic [3:0] src, input logic [1:0] as,
                                            input logic b, input logic [3:0] dst);
      return {4'h4, src, 1'b0, b, as, dst};
   endfunction

   // {isConst, value} that R2 or R3 should give in each mode
   function automatic logic [16:0] expectedSrc(input logic [3:0] src, input logic [1:0] as);
      if (src == 4'd2)
      begin
         case (as)
            2'd0:    return {1'b0, model[2]};       // Plain status register read
            2'd1:    return {1'b1, 16'h0000};       // Absolute mode base
            2'd2:    return {1'b1, 16'h0004};
            default: return {1'b1, 16'h0008};
         endcase
      end
      case (as)
         2'd0:    return {1'b1, 16'h0000};
         2'd1:    return {1'b1, 16'h0001};
         2'd2:    return {1'b1, 16'h0002};
         default: return {1'b1, 16'hFFFF};
      endcase
   endfunction

   task automatic expectEq(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("ERROR %s: got %h, expected %h", name, got, exp);
      end
   endtask

   task automatic coreWrite(input logic [3:0] dst, input logic [15:0] val);
      @(posedge clk);
      instr <= fmt1Word(dst, 2'd0, 1'b0, dst);      // Source equals destination
      rw    <= 1'b1;
      din   <= val;
      @(posedge clk);                               // DUT writes here
      rw <= 1'b0;
      if (dst != regPc && dst != regCg)
         model[dst] = val;                          // R0 reloads pcIn, R3 drops it
      @(negedge clk);
   endtask

   task automatic axiWrite(input logic [3:0] idx, input logic [15:0] val);
      @(posedge clk);
      dbgReq.awaddr  <= {2'b00, idx, 2'b00};
      dbgReq.awvalid <= 1'b1;
      dbgReq.wdata   <= {16'h0000, val};
      dbgReq.wvalid  <= 1'b1;
      dbgReq.bready  <= 1'b1;
      @(posedge clk);                               // Accepted while idle
      dbgReq.awvalid <= 1'b0;
      dbgReq.wvalid  <= 1'b0;
      @(negedge clk);
      while (!dbgRsp.bvalid)
         @(negedge clk);
      @(posedge clk);                               // B handshake
      dbgReq.bready <= 1'b0;
   endtask

   task automatic axiRead(input logic [3:0] idx, output logic [31:0] data);
      @(posedge clk);
      dbgReq.araddr  <= {2'b00, idx, 2'b00};
      dbgReq.arvalid <= 1'b1;
      dbgReq.rready  <= 1'b1;
      @(posedge clk);
      dbgReq.arvalid <= 1'b0;
      @(negedge clk);
      while (!dbgRsp.rvalid)
         @(negedge clk);
      data = dbgRsp.rdata;
      @(posedge clk);                               // R handshake
      dbgReq.rready <= 1'b0;
   endtask

   task automatic resetState();
      logic [31:0] data;
      for (int i = 0; i < numRegs; i++)
      begin
         axiRead(4'(i), data);
         expectEq("rdata", data, 32'h0);
      end
      @(negedge clk);
      expectEq("bvalid", dbgRsp.bvalid, 0);
      expectEq("rvalid", dbgRsp.rvalid, 0);
      expectEq("awready", dbgRsp.awready, 1);
      expectEq("wready", dbgRsp.wready, 1);
      expectEq("arready", dbgRsp.arready, 1);
   endtask

   task automatic writeBackPath();
      logic [3:0] dst;
      repeat (8)
      begin
         dst = 4'(4 + randBits(4) % 12);            // R4 to R15
         coreWrite(dst, randBits(16));
         expectEq("dstOperand", dstOperand, model[dst]);
         expectEq("srcOperand", srcOperand, model[dst]);
      end
      coreWrite(regSp, randBits(16));               // Stack pointer has its own output
      expectEq("spOut", spOut, model[regSp]);
   endtask

   task automatic constantSources();
      logic [16:0] exp;
      coreWrite(regSr, randBits(16));               // Known R2 for mode 0
      for (int s = 2; s < 4; s++)
      begin
         for (int m = 0; m < 4; m++)
         begin
            @(posedge clk);
            instr <= fmt1Word(4'(s), 2'(m), 1'b0, 4'd4);
            @(negedge clk);
            exp = expectedSrc(4'(s), 2'(m));
            expectEq("isConst", isConst, exp[16]);
            expectEq("srcOperand", srcOperand, exp[15:0]);
         end
      end
   endtask

   task automatic formatDecode();
      logic [3:0] r;
      r = 4'(4 + randBits(4) % 12);
      coreWrite(r, randBits(16));
      for (int b = 0; b < 2; b++)
      begin
         @(posedge clk);
         instr <= {9'h020, 1'(b), 2'b00, r};        // Single operand, register mode
         @(negedge clk);
         expectEq("srcOperand", srcOperand, model[r]);
         expectEq("dstOperand", dstOperand, model[r]);
         expectEq("byteOp", byteOp, b);
         @(posedge clk);
         instr <= fmt1Word(r, 2'd0, 1'(b), 4'd5);
         @(negedge clk);
         expectEq("byteOp", byteOp, b);
      end
   endtask

   task automatic specialRegs();
      logic [15:0] v, w;
      repeat (4)
      begin
         v = randBits(16);
         @(posedge clk);
         pcIn <= v;
         @(posedge clk);                            // R0 takes pcIn
         @(negedge clk);
         expectEq("pcOut", pcOut, v);
      end
      model[regPc] = v;
      w = randBits(16);
      coreWrite(regPc, w);
      expectEq("pcOut", pcOut, w);                  // Explicit write wins once
      @(negedge clk);
      expectEq("pcOut", pcOut, model[regPc]);
      v = randBits(16);
      @(posedge clk);
      srIn <= v;
      srWe <= 1'b1;
      @(posedge clk);
      @(negedge clk);
      expectEq("srOut", srOut, v);
      w = randBits(16);
      coreWrite(regSr, w);                          // srWe still high
      expectEq("srOut", srOut, w);
      @(posedge clk);
      srWe <= 1'b0;                                 // Last flag load on this edge
      model[regSr] = v;
      @(negedge clk);
      expectEq("srOut", srOut, v);
      coreWrite(regCg, randBits(16));
      expectEq("srcOperand", srcOperand, 16'h0000);
      expectEq("isConst", isConst, 1);
      expectEq("dstOperand", dstOperand, 16'h0000);
   endtask

   task automatic debugPort();
      logic [3:0]  x;
      logic [15:0] coreVal, dbgVal;
      logic [31:0] data;
      repeat (4)
      begin
         x = 4'(4 + randBits(4) % 12);
         dbgVal = randBits(16);
         axiWrite(x, dbgVal);
         model[x] = dbgVal;
      end
      for (int i = 0; i < numRegs; i++)
      begin
         axiRead(4'(i), data);
         expectEq("rdata", data, {16'h0000, model[i]});
      end
      x = 4'(4 + randBits(4) % 12);
      coreVal = randBits(16);
      dbgVal = randBits(16);
      @(posedge clk);
      dbgReq.awaddr  <= {2'b00, x, 2'b00};
      dbgReq.awvalid <= 1'b1;
      dbgReq.wdata   <= {16'h0000, dbgVal};
      dbgReq.wvalid  <= 1'b1;
      dbgReq.bready  <= 1'b1;
      instr <= fmt1Word(x, 2'd0, 1'b0, x);
      rw    <= 1'b1;
      din   <= coreVal;
      @(posedge clk);                               // AXI accepted, core writes
      dbgReq.awvalid <= 1'b0;
      dbgReq.wvalid  <= 1'b0;
      @(posedge clk);                               // Core still owns the port
      rw <= 1'b0;
      @(negedge clk);
      expectEq("dstOperand", dstOperand, coreVal);
      while (!dbgRsp.bvalid)
         @(negedge clk);
      expectEq("dstOperand", dstOperand, dbgVal);
      @(posedge clk);
      dbgReq.bready <= 1'b0;
      model[x] = dbgVal;
   endtask

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= maxCycles)
      begin
         $display("Timeout after %0d cycles, the DUT stopped answering", cycles);
         $display("Some tests failed");
         $finish;
      end
   end

   initial
   begin
      lfsrState = 32'd80210;
      for (int i = 0; i < numRegs; i++)
         model[i] = 16'h0000;
      rstN   = 1'b0;
      instr  = 16'h0000;
      rw     = 1'b0;
      din    = 16'h0000;
      pcIn   = 16'h0000;                            // R0 stays 0 until test 5
      srIn   = 16'h0000;
      srWe   = 1'b0;
      dbgReq = '0;
      repeat (8) @(posedge clk);
      rstN <= 1'b1;
      resetState();
      writeBackPath();
      constantSources();
      formatDecode();
      specialRegs();
      debugPort();
      @(negedge clk);
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   end

endmodule

//--- msp16RegCore.f
source/msp16Pkg.sv
source/instrDecode.sv
source/constGen.sv
source/regFile.sv
source/debugAxiLite.sv
source/msp16RegCore.sv
sim/clockGen.sv
sim/msp16RegCoreTb.sv

//--- run.sh
#!/bin/sh
# Build and run the register subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary -Wno-fatal -f msp16RegCore.f --top-module msp16RegCoreTb -o simv

./obj_dir/simv > sim.log 2>&1
cat sim.log

if grep -q "Some tests failed" sim.log; then
   echo "Simulation reported failures"
   exit 1
fi
echo "Simulation finished without failures"
